// File: verilog/sid_pkg.sv
package sid_pkg;

    // Register file geometry
    localparam int reg_addr_w = 5;
    localparam int reg_count  = 32;
    localparam int image_w    = 8 * reg_count;

    // Voice register block, voice n starts at 7n
    localparam int voice_count  = 3;
    localparam int voice_stride = 7;
    localparam int off_freq_lo  = 0;
    localparam int off_freq_hi  = 1;
    localparam int off_pw_lo    = 2;
    localparam int off_pw_hi    = 3;
    localparam int off_ctrl     = 4;

    // Control byte bits
    localparam int ctrl_gate  = 0;
    localparam int ctrl_tri   = 4;
    localparam int ctrl_saw   = 5;
    localparam int ctrl_pulse = 6;

    // Low nibble is the master volume
    localparam int addr_mode_vol = 'h18;

    // Synthesis widths
    localparam int phase_w  = 24;
    localparam int wave_w   = 12;
    localparam int sample_w = 16;

    // Host byte, either a command header or a data byte
    typedef union packed {
        struct packed {
            logic                  wr;
            logic [1:0]            rsvd;
            logic [reg_addr_w-1:0] addr;
        } f;
        logic [7:0] raw;
    } host_hdr_u;

endpackage

// File: verilog/sid_bus_if.sv
`timescale 1ns/1ps

module sid_bus_if (
    input  logic                           clk_usb,
    input  logic                           rst_n,
    input  logic [sid_pkg::reg_addr_w-1:0] a_in,
    input  logic [7:0]                     d_in,
    input  logic                           rw,
    input  logic                           cs_n,
    input  logic                           phi2,
    output logic [7:0]                     d_out,
    output logic                           d_oe,
    output logic                           c64_wr,
    output logic                           c64_rd,
    output logic [sid_pkg::reg_addr_w-1:0] c64_addr,
    output logic [7:0]                     c64_wdata,
    input  logic [7:0]                     rdata,
    input  logic                           c64_rd_done,
    output logic                           tick
);

    logic phi2_meta;
    logic phi2_sync;
    logic phi2_prev;
    logic phi2_rise;
    logic phi2_fall;

    // Two-flop synchronizer, then one more stage for edge detection
    always_ff @(posedge clk_usb) begin
        if (!rst_n) begin
            phi2_meta <= 1'b0;
            phi2_sync <= 1'b0;
            phi2_prev <= 1'b0;
        end else begin
            phi2_meta <= phi2;
            phi2_sync <= phi2_meta;
            phi2_prev <= phi2_sync;
        end
    end

    assign phi2_rise = phi2_sync & ~phi2_prev;
    assign phi2_fall = ~phi2_sync & phi2_prev;

    // Strobes follow the detected edge by one cycle
    always_ff @(posedge clk_usb) begin
        if (!rst_n) begin
            c64_wr <= 1'b0;
            c64_rd <= 1'b0;
            tick   <= 1'b0;
        end else begin
            c64_wr <= phi2_fall & ~cs_n & ~rw;
            c64_rd <= phi2_rise & ~cs_n & rw;
            tick   <= phi2_rise;
        end
    end

    // Bus capture at the selected edge
    always_ff @(posedge clk_usb) begin
        if ((phi2_rise || phi2_fall) && !cs_n) begin
            c64_addr <= a_in;
        end
        if (phi2_fall && !cs_n && !rw) begin
            c64_wdata <= d_in;
        end
    end

    // Read byte on the pads until phi2 drops
    always_ff @(posedge clk_usb) begin
        if (!rst_n) begin
            d_oe <= 1'b0;
        end else if (phi2_fall) begin
            d_oe <= 1'b0;
        end else if (c64_rd_done) begin
            d_oe <= 1'b1;
        end
    end

    always_ff @(posedge clk_usb) begin
        if (c64_rd_done) begin
            d_out <= rdata;
        end
    end

    // Strobes come from opposite phi2 edges
    a_wr_rd_excl: assert property (@(posedge clk_usb) disable iff (!rst_n)
        !(c64_wr && c64_rd));

    // C64 reads always win arbitration and return two cycles later
    a_rd_answer: assert property (@(posedge clk_usb) disable iff (!rst_n)
        c64_rd |-> ##2 c64_rd_done);

endmodule

// File: verilog/host_cmd_port.sv
`timescale 1ns/1ps

module host_cmd_port (
    input  logic                           clk_usb,
    input  logic                           rst_n,
    input  logic [7:0]                     out_data,
    input  logic                           out_valid,
    output logic                           host_wr,
    output logic                           host_rd,
    output logic [sid_pkg::reg_addr_w-1:0] host_addr,
    output logic [7:0]                     host_wdata,
    input  logic [7:0]                     rdata,
    input  logic                           host_rd_done,
    output logic [7:0]                     in_data,
    output logic                           in_valid
);

    import sid_pkg::*;

    host_hdr_u byte_in;
    logic      wait_data;

    assign byte_in = host_hdr_u'(out_data);

    // Header or data phase
    always_ff @(posedge clk_usb) begin
        if (!rst_n) begin
            wait_data <= 1'b0;
            host_wr   <= 1'b0;
            host_rd   <= 1'b0;
        end else begin
            host_wr <= 1'b0;
            host_rd <= 1'b0;
            if (out_valid) begin
                if (wait_data) begin
                    host_wr   <= 1'b1;
                    wait_data <= 1'b0;
                end else if (byte_in.f.wr) begin
                    wait_data <= 1'b1;
                end else begin
                    host_rd <= 1'b1;
                end
            end
        end
    end

    // Address comes from the header, data from the byte after it
    always_ff @(posedge clk_usb) begin
        if (out_valid) begin
            if (wait_data) begin
                host_wdata <= byte_in.raw;
            end else begin
                host_addr <= byte_in.f.addr;
            end
        end
    end

    // Response byte back to the host
    always_ff @(posedge clk_usb) begin
        if (!rst_n) begin
            in_valid <= 1'b0;
        end else begin
            in_valid <= host_rd_done;
        end
    end

    always_ff @(posedge clk_usb) begin
        if (host_rd_done) begin
            in_data <= rdata;
        end
    end

endmodule

// File: verilog/reg_arbiter.sv
`timescale 1ns/1ps

module reg_arbiter (
    input  logic                           clk_usb,
    input  logic                           rst_n,
    input  logic                           c64_wr,
    input  logic                           c64_rd,
    input  logic [sid_pkg::reg_addr_w-1:0] c64_addr,
    input  logic [7:0]                     c64_wdata,
    output logic                           c64_rd_done,
    input  logic                           host_wr,
    input  logic                           host_rd,
    input  logic [sid_pkg::reg_addr_w-1:0] host_addr,
    input  logic [7:0]                     host_wdata,
    output logic                           host_rd_done,
    output logic                           rf_we,
    output logic                           rf_re,
    output logic [sid_pkg::reg_addr_w-1:0] rf_addr,
    output logic [7:0]                     rf_wdata,
    input  logic [7:0]                     rf_rdata,
    output logic [7:0]                     rdata
);

    import sid_pkg::*;

    logic                  c64_req;
    logic                  host_req;
    logic                  grant_pend;
    logic                  grant_host;
    logic                  pend_valid;
    logic                  pend_we;
    logic [reg_addr_w-1:0] pend_addr;
    logic [7:0]            pend_wdata;
    logic                  host_tag;

    assign c64_req    = c64_wr | c64_rd;
    assign host_req   = host_wr | host_rd;
    // C64 first, then the waiting host request, then a fresh one
    assign grant_pend = ~c64_req & pend_valid;
    assign grant_host = ~c64_req & ~pend_valid & host_req;

    always_ff @(posedge clk_usb) begin
        if (!rst_n) begin
            rf_we        <= 1'b0;
            rf_re        <= 1'b0;
            pend_valid   <= 1'b0;
            host_tag     <= 1'b0;
            c64_rd_done  <= 1'b0;
            host_rd_done <= 1'b0;
        end else begin
            rf_we <= c64_wr | (grant_pend & pend_we) | (grant_host & host_wr);
            rf_re <= c64_rd | (grant_pend & ~pend_we) | (grant_host & host_rd);
            if (c64_req && host_req) begin
                pend_valid <= 1'b1;
            end else if (grant_pend) begin
                pend_valid <= 1'b0;
            end
            // Tag travels with rf_re to steer the done strobe
            host_tag     <= ~c64_req;
            c64_rd_done  <= rf_re & ~host_tag;
            host_rd_done <= rf_re & host_tag;
        end
    end

    always_ff @(posedge clk_usb) begin
        if (c64_req && host_req) begin
            pend_we    <= host_wr;
            pend_addr  <= host_addr;
            pend_wdata <= host_wdata;
        end
        if (c64_req) begin
            rf_addr  <= c64_addr;
            rf_wdata <= c64_wdata;
        end else if (pend_valid) begin
            rf_addr  <= pend_addr;
            rf_wdata <= pend_wdata;
        end else begin
            rf_addr  <= host_addr;
            rf_wdata <= host_wdata;
        end
    end

    assign rdata = rf_rdata;

    // Host may not issue while its previous request still waits
    a_pend_overflow: assert property (@(posedge clk_usb) disable iff (!rst_n)
        host_req |-> !pend_valid);

    a_we_re_excl: assert property (@(posedge clk_usb) disable iff (!rst_n)
        !(rf_we && rf_re));

endmodule

// File: verilog/sid_regfile.sv
`timescale 1ns/1ps

module sid_regfile (
    input  logic                           clk_usb,
    input  logic                           rst_n,
    input  logic                           rf_we,
    input  logic                           rf_re,
    input  logic [sid_pkg::reg_addr_w-1:0] rf_addr,
    input  logic [7:0]                     rf_wdata,
    output logic [7:0]                     rf_rdata,
    output logic [sid_pkg::image_w-1:0]    image
);

    import sid_pkg::*;

    logic [7:0] regs [reg_count];

    // Register bytes, all zero out of reset
    always_ff @(posedge clk_usb) begin
        if (!rst_n) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= 8'h00;
            end
        end else if (rf_we) begin
            regs[rf_addr] <= rf_wdata;
        end
    end

    // Registered read port
    always_ff @(posedge clk_usb) begin
        if (rf_re) begin
            rf_rdata <= regs[rf_addr];
        end
    end

    // Byte i sits at image[8i+7:8i]
    for (genvar i = 0; i < reg_count; i++) begin : g_image
        assign image[8*i +: 8] = regs[i];
    end

endmodule

// File: verilog/sid_voices.sv
`timescale 1ns/1ps

module sid_voices (
    input  logic                                clk_usb,
    input  logic                                rst_n,
    input  logic                                tick,
    input  logic [sid_pkg::image_w-1:0]         image,
    output logic signed [sid_pkg::sample_w-1:0] sample,
    output logic                                sample_valid
);

    import sid_pkg::*;

    logic [phase_w-1:0]       phase   [voice_count];
    logic [15:0]              freq    [voice_count];
    logic [wave_w-1:0]        pw      [voice_count];
    logic [7:0]               ctrl    [voice_count];
    logic [wave_w-1:0]        wave    [voice_count];
    logic                     active  [voice_count];
    logic signed [wave_w-1:0] contrib [voice_count];
    logic [3:0]               volume;
    logic signed [wave_w+1:0] mix_sum;
    logic signed [wave_w+6:0] mix_prod;
    logic signed [wave_w+6:0] mix_scaled;
    logic                     tick_d;

    function automatic logic [7:0] reg_byte(input logic [image_w-1:0] img, input int addr);
        return img[8*addr +: 8];
    endfunction

    // Voice fields out of the register image
    for (genvar v = 0; v < voice_count; v++) begin : g_fields
        assign freq[v] = {reg_byte(image, v*voice_stride + off_freq_hi),
                          reg_byte(image, v*voice_stride + off_freq_lo)};
        assign pw[v]   = {image[8*(v*voice_stride + off_pw_hi) +: 4],
                          reg_byte(image, v*voice_stride + off_pw_lo)};
        assign ctrl[v] = reg_byte(image, v*voice_stride + off_ctrl);
    end

    assign volume = image[8*addr_mode_vol +: 4];

    // Phase advance on tick, sample one cycle later
    always_ff @(posedge clk_usb) begin
        if (!rst_n) begin
            for (int v = 0; v < voice_count; v++) begin
                phase[v] <= '0;
            end
            tick_d       <= 1'b0;
            sample_valid <= 1'b0;
            sample       <= '0;
        end else begin
            tick_d       <= tick;
            sample_valid <= tick_d;
            if (tick_d) begin
                sample <= mix_scaled[sample_w-1:0];
            end
            if (tick) begin
                for (int v = 0; v < voice_count; v++) begin
                    if (ctrl[v][ctrl_gate]) begin
                        phase[v] <= phase[v] + phase_w'(freq[v]);
                    end
                end
            end
        end
    end

    // Waveform select, pulse over saw over triangle
    always_comb begin
        for (int v = 0; v < voice_count; v++) begin
            if (ctrl[v][ctrl_pulse]) begin
                wave[v] = (phase[v][phase_w-1 -: wave_w] >= pw[v]) ? '1 : '0;
            end else if (ctrl[v][ctrl_saw]) begin
                wave[v] = phase[v][phase_w-1 -: wave_w];
            end else begin
                wave[v] = phase[v][phase_w-2 -: wave_w] ^ {wave_w{phase[v][phase_w-1]}};
            end
            active[v] = ctrl[v][ctrl_gate] &
                        (ctrl[v][ctrl_tri] | ctrl[v][ctrl_saw] | ctrl[v][ctrl_pulse]);
            // Flipping the MSB gives wave minus 2048
            contrib[v] = active[v] ? {~wave[v][wave_w-1], wave[v][wave_w-2:0]} : '0;
        end
    end

    // Mix and master volume
    always_comb begin
        mix_sum = '0;
        for (int v = 0; v < voice_count; v++) begin
            mix_sum = mix_sum + contrib[v];
        end
        mix_prod   = mix_sum * $signed({1'b0, volume});
        mix_scaled = mix_prod >>> 2;
    end

endmodule

// File: verilog/sid_core_top.sv
`timescale 1ns/1ps

module sid_core_top (
    input  logic                                clk_usb,
    input  logic                                rst_n,
    input  logic [sid_pkg::reg_addr_w-1:0]      a_in,
    input  logic [7:0]                          d_in,
    input  logic                                rw,
    input  logic                                cs_n,
    input  logic                                phi2,
    output logic [7:0]                          d_out,
    output logic                                d_oe,
    input  logic [7:0]                          out_data,
    input  logic                                out_valid,
    output logic [7:0]                          in_data,
    output logic                                in_valid,
    output logic signed [sid_pkg::sample_w-1:0] sample,
    output logic                                sample_valid
);

    import sid_pkg::*;

    // C64 requester
    logic                  c64_wr;
    logic                  c64_rd;
    logic [reg_addr_w-1:0] c64_addr;
    logic [7:0]            c64_wdata;
    logic                  c64_rd_done;

    // Host requester
    logic                  host_wr;
    logic                  host_rd;
    logic [reg_addr_w-1:0] host_addr;
    logic [7:0]            host_wdata;
    logic                  host_rd_done;

    // Shared register port
    logic                  rf_we;
    logic                  rf_re;
    logic [reg_addr_w-1:0] rf_addr;
    logic [7:0]            rf_wdata;
    logic [7:0]            rf_rdata;
    logic [7:0]            rdata;
    logic [image_w-1:0]    image;
    logic                  tick;

    sid_bus_if u_bus_if (
        .clk_usb(clk_usb), .rst_n(rst_n), .a_in(a_in), .d_in(d_in),
        .rw(rw), .cs_n(cs_n), .phi2(phi2), .d_out(d_out), .d_oe(d_oe),
        .c64_wr(c64_wr), .c64_rd(c64_rd), .c64_addr(c64_addr), .c64_wdata(c64_wdata),
        .rdata(rdata), .c64_rd_done(c64_rd_done), .tick(tick)
    );

    host_cmd_port u_host (
        .clk_usb(clk_usb), .rst_n(rst_n), .out_data(out_data), .out_valid(out_valid),
        .host_wr(host_wr), .host_rd(host_rd), .host_addr(host_addr),
        .host_wdata(host_wdata), .rdata(rdata), .host_rd_done(host_rd_done),
        .in_data(in_data), .in_valid(in_valid)
    );

    reg_arbiter u_arb (
        .clk_usb(clk_usb), .rst_n(rst_n),
        .c64_wr(c64_wr), .c64_rd(c64_rd), .c64_addr(c64_addr), .c64_wdata(c64_wdata),
        .c64_rd_done(c64_rd_done),
        .host_wr(host_wr), .host_rd(host_rd), .host_addr(host_addr),
        .host_wdata(host_wdata), .host_rd_done(host_rd_done),
        .rf_we(rf_we), .rf_re(rf_re), .rf_addr(rf_addr), .rf_wdata(rf_wdata),
        .rf_rdata(rf_rdata), .rdata(rdata)
    );

    sid_regfile u_regs (
        .clk_usb(clk_usb), .rst_n(rst_n), .rf_we(rf_we), .rf_re(rf_re),
        .rf_addr(rf_addr), .rf_wdata(rf_wdata), .rf_rdata(rf_rdata), .image(image)
    );

    sid_voices u_voices (
        .clk_usb(clk_usb), .rst_n(rst_n), .tick(tick), .image(image),
        .sample(sample), .sample_valid(sample_valid)
    );

endmodule

// File: verification/tb_sid_core.sv
`timescale 1ns/1ps

module tb_sid_core;

    logic        clk_usb;
    logic        rst_n;
    logic [4:0]  a_in;
    logic [7:0]  d_in;
    logic        rw;
    logic        cs_n;
    logic        phi2;
    logic [7:0]  d_out;
    logic        d_oe;
    logic [7:0]  out_data;
    logic        out_valid;
    logic [7:0]  in_data;
    logic        in_valid;
    logic signed [15:0] sample;
    logic        sample_valid;

    // Reference state of the register file and the voices
    logic [7:0]  shadow [32];
    logic [23:0] phase_m [3];
    logic [15:0] last_model;
    int          value_errors;
    int          timeout_errors;

    sid_core_top u_dut (
        .clk_usb(clk_usb), .rst_n(rst_n), .a_in(a_in), .d_in(d_in),
        .rw(rw), .cs_n(cs_n), .phi2(phi2), .d_out(d_out), .d_oe(d_oe),
        .out_data(out_data), .out_valid(out_valid), .in_data(in_data),
        .in_valid(in_valid), .sample(sample), .sample_valid(sample_valid)
    );

    initial begin
        clk_usb = 1'b0;
        forever begin
            #4 clk_usb = ~clk_usb;
        end
    end

    // Expected sample from the waveform and mix rules
    function automatic logic [15:0] model_sample();
        int          sum;
        int          p;
        int          w;
        int          tri_v;
        int          pwv;
        logic [7:0]  c;
        logic [23:0] ph;
        sum = 0;
        for (int v = 0; v < 3; v++) begin
            c     = shadow[v*7+4];
            ph    = phase_m[v];
            p     = int'(ph[23:12]);
            pwv   = int'({shadow[v*7+3][3:0], shadow[v*7+2]});
            tri_v = int'(ph[22:11]);
            if (ph[23]) begin
                tri_v = 4095 - tri_v;
            end
            if (c[6]) begin
                w = (p >= pwv) ? 4095 : 0;
            end else if (c[5]) begin
                w = p;
            end else begin
                w = tri_v;
            end
            if (c[0] && (c[4] || c[5] || c[6])) begin
                sum = sum + w - 2048;
            end
        end
        sum = sum * int'(shadow[24][3:0]);
        sum = sum >>> 2;
        return sum[15:0];
    endfunction

    // One voice tick in the reference
    task automatic advance_model();
        for (int v = 0; v < 3; v++) begin
            if (shadow[v*7+4][0]) begin
                phase_m[v] = phase_m[v] + {8'h00, shadow[v*7+1], shadow[v*7]};
            end
        end
        last_model = model_sample();
    endtask

    task automatic idle_gap();
        int n;
        n = int'($urandom % 5);
        repeat (n) @(posedge clk_usb);
    endtask

    task automatic host_byte(input logic [7:0] b);
        @(posedge clk_usb);
        out_data  <= b;
        out_valid <= 1'b1;
        @(posedge clk_usb);
        out_valid <= 1'b0;
    endtask

    // One phi2 period of 48 clocks, optionally selecting the chip
    task automatic c64_cycle(input logic is_rd, input logic sel, input logic [4:0] addr,
                             input logic [7:0] data, input logic [7:0] exp_rd,
                             input logic inject, input logic [4:0] haddr,
                             input logic [7:0] hdata);
        logic got_s;
        logic got_r;
        got_s = 1'b0;
        got_r = 1'b0;
        @(posedge clk_usb);
        a_in <= addr;
        d_in <= data;
        rw   <= is_rd;
        cs_n <= ~sel;
        repeat (2) @(posedge clk_usb);
        phi2 <= 1'b1;
        advance_model();
        for (int i = 0; i < 24; i++) begin
            @(negedge clk_usb);
            if (sample_valid && !got_s) begin
                got_s = 1'b1;
                if (sample !== last_model) begin
                    $display("** Error sample: got %h expected %h", sample, last_model);
                    value_errors++;
                end
            end
            if (is_rd && sel && d_oe && !got_r) begin
                got_r = 1'b1;
                if (d_out !== exp_rd) begin
                    $display("** Error d_out: got %h expected %h", d_out, exp_rd);
                    value_errors++;
                end
            end
        end
        if (!got_s) begin
            $display("Timed out waiting for sample_valid after a phi2 rising edge");
            timeout_errors++;
        end
        if (is_rd && sel && !got_r) begin
            $display("Timed out waiting for d_oe during a C64 read");
            timeout_errors++;
        end
        @(posedge clk_usb);
        phi2 <= 1'b0;
        if (inject) begin
            @(posedge clk_usb);
            @(posedge clk_usb);
            out_data  <= hdata;
            out_valid <= 1'b1;
            @(posedge clk_usb);
            out_valid <= 1'b0;
            repeat (18) @(posedge clk_usb);
            shadow[haddr] = hdata;
        end else begin
            repeat (21) @(posedge clk_usb);
        end
        if (sel && !is_rd) begin
            shadow[addr] = data;
        end
        cs_n <= 1'b1;
        @(negedge clk_usb);
        if (d_oe !== 1'b0) begin
            $display("** Error d_oe: got %h expected 0", d_oe);
            value_errors++;
        end
    endtask

    task automatic host_read(input logic [4:0] addr, input logic [7:0] exp_rd);
        logic found;
        int   i;
        found = 1'b0;
        i     = 0;
        host_byte({3'b000, addr});
        while (!found && i < 20) begin
            @(negedge clk_usb);
            i++;
            if (in_valid) begin
                found = 1'b1;
                if (in_data !== exp_rd) begin
                    $display("** Error in_data: got %h expected %h", in_data, exp_rd);
                    value_errors++;
                end
            end
        end
        if (!found) begin
            $display("Timed out waiting for in_valid on a host read");
            timeout_errors++;
        end else begin
            @(negedge clk_usb);
            if (in_valid !== 1'b0) begin
                $display("** Error in_valid: got %h expected 0", in_valid);
                value_errors++;
            end
        end
    endtask

    initial begin
        int            fd;
        int            r;
        int            n;
        logic          done;
        logic [63:0]   op;
        logic [8*200-1:0] skip_line;
        logic [7:0]    b1;
        logic [7:0]    b2;
        logic [7:0]    b3;
        logic [7:0]    b4;
        logic [15:0]   exp_s;

        rst_n     = 1'b0;
        a_in      = '0;
        d_in      = '0;
        rw        = 1'b1;
        cs_n      = 1'b1;
        phi2      = 1'b0;
        out_data  = '0;
        out_valid = 1'b0;
        value_errors   = 0;
        timeout_errors = 0;
        last_model     = '0;
        for (int i = 0; i < 32; i++) begin
            shadow[i] = 8'h00;
        end
        for (int v = 0; v < 3; v++) begin
            phase_m[v] = '0;
        end
        r = int'($urandom(46));

        repeat (16) @(posedge clk_usb);
        rst_n <= 1'b1;

        // Quiet outputs right after reset
        for (int i = 0; i < 10; i++) begin
            @(negedge clk_usb);
            if (sample !== 16'h0000) begin
                $display("** Error sample: got %h expected 0000", sample);
                value_errors++;
            end
            if (in_valid !== 1'b0) begin
                $display("** Error in_valid: got %h expected 0", in_valid);
                value_errors++;
            end
            if (d_oe !== 1'b0) begin
                $display("** Error d_oe: got %h expected 0", d_oe);
                value_errors++;
            end
        end

        fd = $fopen("verification/sid_trace.txt", "r");
        done = (fd == 0);
        if (fd == 0) begin
            $display("Could not open the trace file");
            value_errors++;
        end
        while (!done) begin
            r = $fscanf(fd, "%s", op);
            if (r != 1) begin
                done = 1'b1;
            end else begin
                idle_gap();
                case (op)
                    "#": r = $fgets(skip_line, fd);
                    "W": begin
                        r = $fscanf(fd, "%h %h", b1, b2);
                        c64_cycle(1'b0, 1'b1, b1[4:0], b2, 8'h00, 1'b0, 5'd0, 8'h00);
                    end
                    "R": begin
                        r = $fscanf(fd, "%h %h", b1, b2);
                        c64_cycle(1'b1, 1'b1, b1[4:0], 8'h00, b2, 1'b0, 5'd0, 8'h00);
                    end
                    "H": begin
                        r = $fscanf(fd, "%h %h", b1, b2);
                        host_byte({3'b100, b1[4:0]});
                        idle_gap();
                        host_byte(b2);
                        repeat (4) @(posedge clk_usb);
                        shadow[b1[4:0]] = b2;
                    end
                    "Q": begin
                        r = $fscanf(fd, "%h %h", b1, b2);
                        host_read(b1[4:0], b2);
                    end
                    "X": begin
                        r = $fscanf(fd, "%h %h %h %h", b1, b2, b3, b4);
                        host_byte({3'b100, b3[4:0]});
                        c64_cycle(1'b0, 1'b1, b1[4:0], b2, 8'h00, 1'b1, b3[4:0], b4);
                    end
                    "T": begin
                        r = $fscanf(fd, "%d", n);
                        repeat (n) begin
                            c64_cycle(1'b0, 1'b0, 5'd0, 8'h00, 8'h00, 1'b0, 5'd0, 8'h00);
                        end
                    end
                    "S": begin
                        r = $fscanf(fd, "%h", exp_s);
                        if (last_model !== exp_s) begin
                            $display("** Error sample_model: got %h expected %h",
                                     last_model, exp_s);
                            value_errors++;
                        end
                        if (sample !== exp_s) begin
                            $display("** Error sample: got %h expected %h", sample, exp_s);
                            value_errors++;
                        end
                    end
                    default: begin
                        $display("Unknown opcode in the trace file");
                        value_errors++;
                    end
                endcase
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        $display("Errors: %0d value, %0d timeout", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: verification/sid_trace.txt
# W addr data | R addr expect | H addr data | Q addr expect | T ticks (decimal)
# X addr data host_addr host_data | S expected sample, 16-bit hex
W 05 3c
R 05 3c
R 0b 00
H 09 a5
R 09 a5
W 0c 5a
Q 0c 5a
Q 1f 00
X 0d 11 0f 22
R 0d 11
Q 0f 22
W 18 0f
W 00 00
W 01 80
W 04 21
T 4
S e278
T 60
S e980
W 04 11
T 1
S f178
W 02 00
W 03 08
W 04 41
T 1
S e200
W 03 01
T 1
S 1dfc
W 04 40
T 5
S 0000
W 04 21
T 1
S eaac
R 04 21
Q 18 0f

// File: project.f
verilog/sid_pkg.sv
verilog/sid_bus_if.sv
verilog/host_cmd_port.sv
verilog/reg_arbiter.sv
verilog/sid_regfile.sv
verilog/sid_voices.sv
verilog/sid_core_top.sv
verification/tb_sid_core.sv

// File: Makefile
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f project.f --top-module tb_sid_core \
		-Mdir obj_dir -o sim_tb

run: compile
	./obj_dir/sim_tb | tee sim.log
	grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log
